// File: verilog/dekoder_consts.svh
`ifndef DEKODER_CONSTS_SVH
`define DEKODER_CONSTS_SVH

// format codes in bits 31:30
`define REGISTER_FORMAT  2'b00
`define JUMP_FORMAT      2'b01

// bit 31 alone marks the immediate format
`define IMMEDIATE_FORMAT 1'b1

// function groups in bits 5:4 of a register format word
`define ARITHMETIK       2'b00
`define VERGLEICH        2'b01
`define GLEITKOMMA       2'b10
`define VEKTOR           2'b11

// opcodes in bits 31:26
`define STORE_CODE       6'b101100
`define LOADS_CODE       6'b101011
`define LOAD_CODE        6'b101010
`define JAL_CODE         6'b101111
`define JMP_CODE         6'b010000
`define BEZ_CODE         6'b101110
`define JREG_CODE        6'b101101

`endif

// File: verilog/dekoderPaket.sv
package dekoderPaket;

    // one raw instruction word as it arrives from fetch
    typedef logic [31:0] instruktion_t;

    // bit 5 selects the float bank, bits 4:0 the register inside the bank
    typedef logic [5:0] registerNummer_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction class flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic jalBefehl;          // jump and link, also counts as relative jump
        logic relativerSprung;
        logic absoluterSprung;    // target comes from a register
        logic floatBefehl;
        logic loadBefehl;
        logic storeBefehl;
        logic unbedingterSprung;
        logic bedingterSprung;
    } befehlsArt_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decoded record handed to the next stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        registerNummer_t quellRegister1;
        registerNummer_t quellRegister2;
        registerNummer_t zielRegister;
        logic [25:0]     iDaten;                 // small immediate sign extended or jump field
        logic            kleinerImmediateAktiv;
        logic            grosserImmediateAktiv;
        logic [5:0]      funktionsCode;
        befehlsArt_t     art;
    } dekodierterBefehl_t;

endpackage

// File: verilog/befehlsAnnahme.sv
`timescale 1ns/1ps

module befehlsAnnahme import dekoderPaket::*; (
    input  logic         DekodierSignal,
    input  logic         Reset,
    input  logic         eingangReq,
    input  instruktion_t eingangBefehl,
    input  logic         dekoderFrei,
    output logic         eingangAck,
    output logic         befehlGueltig,
    output instruktion_t befehl
);

    typedef enum logic [1:0] {
        leer,
        wartenAufReqFall,
        belegt
    } annahmeZustand_t;

    annahmeZustand_t zustand;
    instruktion_t    befehlPuffer;
    logic            weitergabe;

    assign weitergabe = befehlGueltig && dekoderFrei;  // word moves into the decoder on this edge

    always_ff @(posedge DekodierSignal or posedge Reset) begin
        if (Reset) begin
            zustand       <= leer;
            befehlGueltig <= 1'b0;
        end else begin
            case (zustand)
                leer: begin
                    if (eingangReq) begin
                        zustand       <= wartenAufReqFall;  // ack rises together with the latch
                        befehlGueltig <= 1'b1;
                    end
                end
                wartenAufReqFall: begin
                    if (!eingangReq) begin
                        zustand <= (befehlGueltig && !weitergabe) ? belegt : leer;
                    end
                    if (weitergabe) begin
                        befehlGueltig <= 1'b0;
                    end
                end
                default: begin
                    if (weitergabe) begin
                        zustand       <= leer;
                        befehlGueltig <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge DekodierSignal) begin
        if (zustand == leer && eingangReq) begin
            befehlPuffer <= eingangBefehl;
        end
    end

    assign eingangAck = (zustand == wartenAufReqFall);
    assign befehl     = befehlPuffer;

    ackNurBeiReq: assert property (@(posedge DekodierSignal) disable iff (Reset)
        $rose(eingangAck) |-> eingangReq);

    pufferStabil: assert property (@(posedge DekodierSignal) disable iff (Reset)
        befehlGueltig |=> $stable(befehl));

endmodule

// File: verilog/instruktionsDekodierer.sv
`timescale 1ns/1ps
`include "dekoder_consts.svh"

module instruktionsDekodierer import dekoderPaket::*; (
    input  logic               DekodierSignal,
    input  logic               Reset,
    input  logic               befehlGueltig,
    input  instruktion_t       befehl,
    input  logic               abgabeFrei,
    output logic               dekoderFrei,
    output logic               ergebnisGueltig,
    output dekodierterBefehl_t ergebnis
);

    instruktion_t aktuellerBefehl;
    logic         stufeBelegt;

    logic [5:0]   opcode;
    logic         registerFormat;
    logic         immediateFormat;
    logic         gleitkommaGruppe;
    logic [4:0]   zRegister;
    logic [4:0]   q1Register;
    logic [4:0]   q2Register;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction register and stage flag
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the stage is free when empty or when its record leaves on this edge
    assign dekoderFrei     = !stufeBelegt || abgabeFrei;
    assign ergebnisGueltig = stufeBelegt;

    always_ff @(posedge DekodierSignal or posedge Reset) begin
        if (Reset) begin
            aktuellerBefehl <= '0;
            stufeBelegt     <= 1'b0;
        end else begin
            if (befehlGueltig && dekoderFrei) begin
                aktuellerBefehl <= befehl;
                stufeBelegt     <= 1'b1;
            end else if (stufeBelegt && abgabeFrei) begin
                stufeBelegt <= 1'b0;  // record handed on and nothing new arrived
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign opcode           = aktuellerBefehl[31:26];
    assign registerFormat   = (aktuellerBefehl[31:30] == `REGISTER_FORMAT);
    assign immediateFormat  = (aktuellerBefehl[31] == `IMMEDIATE_FORMAT);
    assign gleitkommaGruppe = (aktuellerBefehl[5:4] == `GLEITKOMMA);
    assign zRegister        = aktuellerBefehl[25:21];
    assign q1Register       = aktuellerBefehl[20:16];
    assign q2Register       = aktuellerBefehl[15:11];

    always_comb begin
        ergebnis = '0;

        if (registerFormat) begin
            ergebnis.quellRegister1 = {gleitkommaGruppe, q1Register};  // float group uses bank 1
            ergebnis.quellRegister2 = {gleitkommaGruppe, q2Register};
            ergebnis.zielRegister   = {gleitkommaGruppe, zRegister};
            ergebnis.funktionsCode  = aktuellerBefehl[5:0];
        end else if (immediateFormat) begin
            ergebnis.quellRegister1        = {1'b0, q1Register};
            ergebnis.zielRegister          = {opcode == `LOADS_CODE, zRegister};
            ergebnis.iDaten                = {{10{aktuellerBefehl[15]}}, aktuellerBefehl[15:0]};
            ergebnis.kleinerImmediateAktiv = 1'b1;
            if (opcode == `STORE_CODE) begin
                ergebnis.quellRegister2 = {1'b0, zRegister};  // store data register sits in the dest field
            end
            // loads, stores and jumps in this range carry no function code
            if (opcode >= `LOAD_CODE && opcode <= `JAL_CODE) begin
                ergebnis.funktionsCode = 6'b0;
            end else begin
                ergebnis.funktionsCode = {1'b0, aktuellerBefehl[30:26]};
            end
        end else begin
            ergebnis.iDaten                = aktuellerBefehl[25:0];  // only the jump format is left
            ergebnis.grosserImmediateAktiv = 1'b1;
        end

        ergebnis.art.jalBefehl         = (opcode == `JAL_CODE);
        ergebnis.art.relativerSprung   = (opcode == `JAL_CODE) || (opcode == `JMP_CODE)
                                         || (opcode == `BEZ_CODE);
        ergebnis.art.absoluterSprung   = (opcode == `JREG_CODE);
        ergebnis.art.floatBefehl       = (registerFormat && gleitkommaGruppe)
                                         || (opcode == `LOADS_CODE);
        ergebnis.art.loadBefehl        = (opcode == `LOAD_CODE) || (opcode == `LOADS_CODE);
        ergebnis.art.storeBefehl       = (opcode == `STORE_CODE);
        ergebnis.art.unbedingterSprung = (opcode == `JREG_CODE) || (opcode == `JAL_CODE)
                                         || (opcode == `JMP_CODE);
        ergebnis.art.bedingterSprung   = (opcode == `BEZ_CODE);
    end

    // a float record is a register op without immediate or the LoadS load,
    // and its destination then sits in the float bank
    floatNurRegOderLoadS: assert property (@(posedge DekodierSignal) disable iff (Reset)
        (ergebnisGueltig && ergebnis.art.floatBefehl)
        |-> (ergebnis.zielRegister[5]
             && ((!ergebnis.kleinerImmediateAktiv && !ergebnis.grosserImmediateAktiv)
                 || ergebnis.art.loadBefehl)));

    einImmediate: assert property (@(posedge DekodierSignal) disable iff (Reset)
        ergebnisGueltig |-> $onehot0({ergebnis.kleinerImmediateAktiv,
                                      ergebnis.grosserImmediateAktiv}));

endmodule

// File: verilog/ergebnisAbgabe.sv
`timescale 1ns/1ps

module ergebnisAbgabe import dekoderPaket::*; (
    input  logic               DekodierSignal,
    input  logic               Reset,
    input  logic               ergebnisGueltig,
    input  dekodierterBefehl_t ergebnis,
    input  logic               ausgangAck,
    output logic               abgabeFrei,
    output logic               ausgangReq,
    output dekodierterBefehl_t ausgangDaten
);

    typedef enum logic [1:0] {
        frei,
        senden,
        wartenAufAckFall
    } abgabeZustand_t;

    abgabeZustand_t     zustand;
    dekodierterBefehl_t datenRegister;

    assign abgabeFrei = (zustand == frei);

    always_ff @(posedge DekodierSignal or posedge Reset) begin
        if (Reset) begin
            zustand <= frei;
        end else begin
            case (zustand)
                frei: begin
                    if (ergebnisGueltig) begin
                        zustand <= senden;  // req rises with the load
                    end
                end
                senden: begin
                    if (ausgangAck) begin
                        zustand <= wartenAufAckFall;
                    end
                end
                default: begin
                    if (!ausgangAck) begin
                        zustand <= frei;  // consumer finished, stage may load again
                    end
                end
            endcase
        end
    end

    always_ff @(posedge DekodierSignal) begin
        if (ergebnisGueltig && abgabeFrei) begin
            datenRegister <= ergebnis;
        end
    end

    assign ausgangReq   = (zustand == senden);
    assign ausgangDaten = datenRegister;

    // the record has to stay put for the whole time the consumer may sample it
    datenStabil: assert property (@(posedge DekodierSignal) disable iff (Reset)
        ausgangReq |=> $stable(ausgangDaten));

endmodule

// File: verilog/dekodierEinheit.sv
`timescale 1ns/1ps

module dekodierEinheit import dekoderPaket::*; (
    input  logic               DekodierSignal,
    input  logic               Reset,
    input  logic               eingangReq,
    input  instruktion_t       eingangBefehl,
    input  logic               ausgangAck,
    output logic               eingangAck,
    output logic               ausgangReq,
    output dekodierterBefehl_t ausgangDaten
);

    logic               befehlGueltig;
    instruktion_t       befehl;
    logic               dekoderFrei;
    logic               ergebnisGueltig;
    dekodierterBefehl_t ergebnis;
    logic               abgabeFrei;

    befehlsAnnahme annahme_i (
        .DekodierSignal (DekodierSignal),
        .Reset          (Reset),
        .eingangReq     (eingangReq),
        .eingangBefehl  (eingangBefehl),
        .dekoderFrei    (dekoderFrei),
        .eingangAck     (eingangAck),
        .befehlGueltig  (befehlGueltig),
        .befehl         (befehl)
    );

    instruktionsDekodierer dekodierer_i (
        .DekodierSignal  (DekodierSignal),
        .Reset           (Reset),
        .befehlGueltig   (befehlGueltig),
        .befehl          (befehl),
        .abgabeFrei      (abgabeFrei),
        .dekoderFrei     (dekoderFrei),
        .ergebnisGueltig (ergebnisGueltig),
        .ergebnis        (ergebnis)
    );

    ergebnisAbgabe abgabe_i (
        .DekodierSignal  (DekodierSignal),
        .Reset           (Reset),
        .ergebnisGueltig (ergebnisGueltig),
        .ergebnis        (ergebnis),
        .ausgangAck      (ausgangAck),
        .abgabeFrei      (abgabeFrei),
        .ausgangReq      (ausgangReq),
        .ausgangDaten    (ausgangDaten)
    );

endmodule

// File: tests/dekodierReferenz.svh
`ifndef DEKODIER_REFERENZ_SVH
`define DEKODIER_REFERENZ_SVH

`include "dekoder_consts.svh"

// expected record for one instruction word, built from the decode rules
function automatic dekodierterBefehl_t referenzDekodieren(input instruktion_t wort);
    dekodierterBefehl_t erwartung;
    logic [5:0]         op;
    logic               floatBank;
    erwartung = '0;
    op        = wort[31:26];
    floatBank = (wort[5:4] == `GLEITKOMMA);

    case (wort[31:30])
        `REGISTER_FORMAT: begin
            erwartung.quellRegister1      = {floatBank, wort[20:16]};
            erwartung.quellRegister2      = {floatBank, wort[15:11]};
            erwartung.zielRegister        = {floatBank, wort[25:21]};
            erwartung.funktionsCode       = wort[5:0];
            erwartung.art.floatBefehl     = floatBank;
        end
        `JUMP_FORMAT: begin
            erwartung.iDaten                = wort[25:0];
            erwartung.grosserImmediateAktiv = 1'b1;
        end
        default: begin
            erwartung.quellRegister1        = {1'b0, wort[20:16]};
            erwartung.zielRegister          = {1'b0, wort[25:21]};
            erwartung.iDaten                = {{10{wort[15]}}, wort[15:0]};
            erwartung.kleinerImmediateAktiv = 1'b1;
            if (!(op inside {[`LOAD_CODE:`JAL_CODE]})) begin
                erwartung.funktionsCode = {1'b0, wort[30:26]};
            end
            if (op == `STORE_CODE) begin
                erwartung.quellRegister2 = {1'b0, wort[25:21]};
            end
            if (op == `LOADS_CODE) begin
                erwartung.zielRegister[5] = 1'b1;  // LoadS writes the float bank
            end
        end
    endcase

    case (op)
        `JAL_CODE: begin
            erwartung.art.jalBefehl         = 1'b1;
            erwartung.art.relativerSprung   = 1'b1;
            erwartung.art.unbedingterSprung = 1'b1;
        end
        `JMP_CODE: begin
            erwartung.art.relativerSprung   = 1'b1;
            erwartung.art.unbedingterSprung = 1'b1;
        end
        `BEZ_CODE: begin
            erwartung.art.relativerSprung = 1'b1;
            erwartung.art.bedingterSprung = 1'b1;
        end
        `JREG_CODE: begin
            erwartung.art.absoluterSprung   = 1'b1;
            erwartung.art.unbedingterSprung = 1'b1;
        end
        `LOAD_CODE:  erwartung.art.loadBefehl = 1'b1;
        `LOADS_CODE: begin
            erwartung.art.loadBefehl  = 1'b1;
            erwartung.art.floatBefehl = 1'b1;
        end
        `STORE_CODE: erwartung.art.storeBefehl = 1'b1;
        default: ;
    endcase
    return erwartung;
endfunction

// linear congruential generator for the random words
function automatic logic [31:0] naechsterZufall(input logic [31:0] zustand);
    return zustand * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// File: tests/dekodierEinheitTb.sv
`timescale 1ns/1ps

module dekodierEinheitTb import dekoderPaket::*; ();

    localparam int          WARTE_GRENZE = 200;
    localparam logic [31:0] STARTWERT    = 32'hd7515fe7;

    logic               DekodierSignal;
    logic               Reset;
    logic               eingangReq;
    instruktion_t       eingangBefehl;
    logic               ausgangAck;
    logic               eingangAck;
    logic               ausgangReq;
    dekodierterBefehl_t ausgangDaten;

    instruktion_t       stimulus[$];
    instruktion_t       erwartet[$];
    dekodierterBefehl_t empfangen[$];
    string              testName;
    int                 angenommen;
    int                 abgeliefert;
    int                 maxBelegt;
    int                 vergleiche;
    logic [31:0]        zufall;

    `include "dekodierReferenz.svh"

    dekodierEinheit dut_i (
        .DekodierSignal (DekodierSignal),
        .Reset          (Reset),
        .eingangReq     (eingangReq),
        .eingangBefehl  (eingangBefehl),
        .ausgangAck     (ausgangAck),
        .eingangAck     (eingangAck),
        .ausgangReq     (ausgangReq),
        .ausgangDaten   (ausgangDaten)
    );

    initial begin
        DekodierSignal = 1'b0;
        forever #50 DekodierSignal = ~DekodierSignal;
    end

    task automatic abbrechen(input string meldung);
        $display("%s", meldung);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic pruefeSignal(input string name, input logic soll, input logic ist);
        if (ist !== soll) begin
            abbrechen($sformatf("FAIL %s: expected %b, actual %b", name, soll, ist));
        end
    endtask

    task automatic pruefeBefehl(input string name, input dekodierterBefehl_t soll,
                                input dekodierterBefehl_t ist);
        dekodierterBefehl_t sollFelder;
        dekodierterBefehl_t istFelder;
        sollFelder     = soll;
        istFelder      = ist;
        sollFelder.art = '0;  // flags go through pruefeArt
        istFelder.art  = '0;
        if (istFelder !== sollFelder) begin
            abbrechen($sformatf("FAIL %s: expected %h, actual %h", name, sollFelder, istFelder));
        end
    endtask

    task automatic pruefeArt(input string name, input befehlsArt_t soll, input befehlsArt_t ist);
        if (ist !== soll) begin
            abbrechen($sformatf("FAIL %s flags: expected %b, actual %b", name, soll, ist));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake waits, driver and consumer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic warteAufEingangAck(input logic wert);
        int zyklen;
        zyklen = 0;
        @(negedge DekodierSignal);
        while (eingangAck !== wert) begin
            zyklen++;
            if (zyklen > WARTE_GRENZE) begin
                abbrechen($sformatf("timeout in %s while waiting for eingangAck to become %b",
                                    testName, wert));
            end
            @(negedge DekodierSignal);
        end
    endtask

    task automatic warteAufAusgangReq(input logic wert);
        int zyklen;
        zyklen = 0;
        @(negedge DekodierSignal);
        while (ausgangReq !== wert) begin
            zyklen++;
            if (zyklen > WARTE_GRENZE) begin
                abbrechen($sformatf("timeout in %s while waiting for ausgangReq to become %b",
                                    testName, wert));
            end
            @(negedge DekodierSignal);
        end
    endtask

    task automatic sendeBefehl(input instruktion_t wort);
        @(posedge DekodierSignal);
        eingangBefehl <= wort;
        eingangReq    <= 1'b1;
        erwartet.push_back(wort);
        warteAufEingangAck(1'b1);
        angenommen++;
        if (angenommen - abgeliefert > 3) begin
            abbrechen($sformatf("in %s more than three words were held inside the DUT", testName));
        end
        if (angenommen - abgeliefert > maxBelegt) begin
            maxBelegt = angenommen - abgeliefert;
        end
        @(posedge DekodierSignal);
        eingangReq <= 1'b0;
        warteAufEingangAck(1'b0);
    endtask

    task automatic nimmAb(input int anzahl, input int verzoegerung);
        for (int i = 0; i < anzahl; i++) begin
            warteAufAusgangReq(1'b1);
            empfangen.push_back(ausgangDaten);  // record is stable while req is high
            repeat (verzoegerung) @(posedge DekodierSignal);
            @(posedge DekodierSignal);
            ausgangAck <= 1'b1;
            warteAufAusgangReq(1'b0);
            repeat (verzoegerung) @(posedge DekodierSignal);
            @(posedge DekodierSignal);
            ausgangAck <= 1'b0;
            abgeliefert++;
        end
    endtask

    task automatic warteBisVerglichen();
        int zyklen;
        zyklen = 0;
        @(negedge DekodierSignal);
        while (erwartet.size() != 0 || empfangen.size() != 0) begin
            zyklen++;
            if (zyklen > WARTE_GRENZE) begin
                abbrechen($sformatf("in %s %0d words never came out decoded",
                                    testName, erwartet.size()));
            end
            @(negedge DekodierSignal);
        end
    endtask

    task automatic laufeTest(input string name, input int verzoegerung);
        int anzahl;
        testName = name;
        anzahl   = stimulus.size();
        fork
            begin
                for (int i = 0; i < anzahl; i++) begin
                    sendeBefehl(stimulus[i]);
                end
            end
            nimmAb(anzahl, verzoegerung);
        join
        warteBisVerglichen();
        stimulus.delete();
    endtask

    // compare process, pairs each received record with the oldest word sent
    initial begin : vergleich
        instruktion_t       wort;
        dekodierterBefehl_t soll;
        dekodierterBefehl_t ist;
        forever begin
            @(negedge DekodierSignal);
            while (empfangen.size() > 0) begin
                ist = empfangen.pop_front();
                if (erwartet.size() == 0) begin
                    abbrechen($sformatf("in %s a record came out with no word sent", testName));
                end
                wort = erwartet.pop_front();
                soll = referenzDekodieren(wort);
                pruefeBefehl($sformatf("%s word %0d", testName, vergleiche), soll, ist);
                pruefeArt($sformatf("%s word %0d", testName, vergleiche), soll.art, ist.art);
                vergleiche++;
            end
        end
    end

    initial begin
        Reset         <= 1'b1;
        eingangReq    <= 1'b0;
        eingangBefehl <= '0;
        ausgangAck    <= 1'b0;
        angenommen    = 0;
        abgeliefert   = 0;
        maxBelegt     = 0;
        vergleiche    = 0;
        testName      = "reset";
        zufall        = STARTWERT;
        repeat (4) @(posedge DekodierSignal);
        Reset <= 1'b0;

        @(negedge DekodierSignal);
        pruefeSignal("reset eingangAck", 1'b0, eingangAck);
        pruefeSignal("reset ausgangReq", 1'b0, ausgangReq);
        stimulus.push_back({6'b000000, 5'd7, 5'd1, 5'd2, 5'd0, 6'b000011});
        laufeTest("first word", 0);

        // integer groups, then the float group with bank bit 1
        stimulus.push_back({6'b000000, 5'd3, 5'd4, 5'd5, 5'd0, 6'b000001});
        stimulus.push_back({6'b001010, 5'd31, 5'd30, 5'd29, 5'd21, 6'b010101});
        stimulus.push_back({6'b000000, 5'd9, 5'd10, 5'd11, 5'd0, 6'b100110});
        stimulus.push_back({6'b000011, 5'd17, 5'd0, 5'd31, 5'd3, 6'b101111});
        stimulus.push_back({6'b000000, 5'd12, 5'd13, 5'd14, 5'd0, 6'b111000});
        laufeTest("register format", 0);

        stimulus.push_back({6'b100001, 5'd2, 5'd3, 16'h1234});
        stimulus.push_back({6'b100001, 5'd2, 5'd3, 16'hfff0});  // negative immediate
        stimulus.push_back({6'b110001, 5'd4, 5'd5, 16'h8000});
        stimulus.push_back({`LOAD_CODE, 5'd6, 5'd7, 16'h0010});
        stimulus.push_back({`LOADS_CODE, 5'd8, 5'd9, 16'hff00});
        stimulus.push_back({`STORE_CODE, 5'd10, 5'd11, 16'h0004});
        stimulus.push_back({`JAL_CODE, 5'd31, 5'd0, 16'h0100});
        stimulus.push_back({`BEZ_CODE, 5'd0, 5'd12, 16'hfffc});
        stimulus.push_back({`JREG_CODE, 5'd0, 5'd13, 16'h0000});
        laufeTest("immediate format", 0);

        stimulus.push_back({`JMP_CODE, 26'h1234567});
        stimulus.push_back({`JMP_CODE, 26'h3fffffe});
        laufeTest("jump format", 0);

        for (int i = 0; i < 200; i++) begin
            zufall = naechsterZufall(zufall);
            stimulus.push_back(zufall);
        end
        laufeTest("random words", 0);

        maxBelegt = 0;
        for (int i = 0; i < 24; i++) begin
            zufall = naechsterZufall(zufall);
            stimulus.push_back(zufall);
        end
        laufeTest("back pressure", 6);  // slow consumer fills every stage
        if (maxBelegt != 3) begin
            abbrechen($sformatf("back pressure filled only %0d of three stages", maxBelegt));
        end

        // every word has been taken, so no further record may be offered
        repeat (4) @(negedge DekodierSignal);
        if (ausgangReq === 1'b0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abbrechen("the DUT offered a record after the last word had been taken");
        end
    end

endmodule

// File: dekodierEinheit.f
+incdir+verilog
+incdir+tests
verilog/dekoderPaket.sv
verilog/befehlsAnnahme.sv
verilog/instruktionsDekodierer.sv
verilog/ergebnisAbgabe.sv
verilog/dekodierEinheit.sv
tests/dekodierEinheitTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f dekodierEinheit.f \
		--top-module dekodierEinheitTb -o dekodierSim
	@ausgabe="$$(./obj_dir/dekodierSim)"; echo "$$ausgabe"; \
		echo "$$ausgabe" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
